/* source/ppu_params.svh */
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// Visible screen size in pixels
`define PPU_SCREEN_WIDTH 160
`define PPU_SCREEN_HEIGHT 144

// Pixels carried by one row entry, one tile row wide
`define PPU_ROW_PIXELS 8

// Row entries held by the pixel FIFO by default
`define PPU_FIFO_DEPTH 4

`endif

/* source/ppu_types_pkg.sv */
`include "ppu_params.svh"

package ppu_types_pkg;

  // One DMG shade, 0 is lightest and 3 is darkest
  typedef logic [1:0] gb_color_t;

  // Two bitplane bytes of one tile row
  // Bit 7 of each plane is the leftmost pixel
  typedef struct packed {
    logic [7:0] plane_hi;
    logic [7:0] plane_lo;
  } tile_row_t;

  // Eight palette-mapped shades
  // Index 0 is leftmost and sits in the top two bits,
  // same order as the bitplanes in VRAM
  typedef gb_color_t [0:`PPU_ROW_PIXELS-1] pixel_row_t;

  // Raw 2-bit color number before the palette
  typedef logic [1:0] color_num_t;

  // Pixel index into the frame store, line * 160 + column
  typedef logic [14:0] pixel_addr_t;

endpackage

/* source/ppu_ctrl_pkg.sv */
package ppu_ctrl_pkg;

  import ppu_types_pkg::*;

  // BGP register layout
  // Bits 7:6 map color number 3, bits 1:0 map color number 0
  typedef struct packed {
    gb_color_t shade3;
    gb_color_t shade2;
    gb_color_t shade1;
    gb_color_t shade0;
  } palette_t;

  // Framebuffer status toward the rest of the PPU
  // line_done and frame_done are single-cycle pulses
  // ly is the line the pulses refer to
  typedef struct packed {
    logic       line_done;
    logic       frame_done;
    logic [7:0] ly;
  } fb_status_t;

endpackage

/* source/pixel_row_fetcher.sv */
`timescale 1ns/10ps

`include "ppu_params.svh"

module pixel_row_fetcher
  import ppu_types_pkg::*;
  import ppu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       tile_valid,
  input  tile_row_t  tile_row,
  input  palette_t   bgp,
  output logic       tile_ready,
  input  logic       fifo_full,
  output logic       push,
  output pixel_row_t push_row
);

  localparam int ROW_MSB = `PPU_ROW_PIXELS - 1;

  logic       accept;
  pixel_row_t decoded_row;

  // Color number through BGP
  function automatic gb_color_t map_shade(input palette_t pal, input color_num_t num);
    case (num)
      2'd0:    return pal.shade0;
      2'd1:    return pal.shade1;
      2'd2:    return pal.shade2;
      default: return pal.shade3;
    endcase
  endfunction

  // No new tile while the FIFO is full or the last one still waits to push
  assign tile_ready = !fifo_full && !push;
  assign accept     = tile_valid && tile_ready;

  // Bit 7 of both planes is pixel 0
  // High plane gives the upper bit of the color number
  always_comb begin
    for (int i = 0; i <= ROW_MSB; i++) begin
      decoded_row[i] = map_shade(bgp, {tile_row.plane_hi[ROW_MSB - i],
                                       tile_row.plane_lo[ROW_MSB - i]});
    end
  end

  // Push strobe one cycle after acceptance
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      push <= 1'b0;
    end else if (flush) begin
      // Pending row dropped together with the FIFO contents
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  // Decoded row held for the push cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      push_row <= decoded_row;
    end
  end

endmodule

/* source/pixel_row_fifo.sv */
`timescale 1ns/10ps

`include "ppu_params.svh"

module pixel_row_fifo
  import ppu_types_pkg::*;
#(
  parameter int DEPTH = `PPU_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       push,
  input  pixel_row_t push_row,
  input  logic       pop,
  output pixel_row_t head_row,
  output logic       empty,
  output logic       full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  pixel_row_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Push into a full FIFO or pop from an empty one is ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // Fall-through head, valid while not empty
  assign head_row = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  // Row storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_row;
    end
  end

endmodule

/* source/framebuffer_writer.sv */
`timescale 1ns/10ps

`include "ppu_params.svh"

module framebuffer_writer
  import ppu_types_pkg::*;
  import ppu_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        dot_en,
  input  logic        fifo_empty,
  input  pixel_row_t  head_row,
  output logic        pop,
  output logic        wr_en,
  output logic [14:0] wr_addr,
  output pixel_row_t  wr_row,
  output fb_status_t  status
);

  localparam logic [7:0]  LAST_COL  = 8'(`PPU_SCREEN_WIDTH - `PPU_ROW_PIXELS);
  localparam logic [7:0]  LAST_LINE = 8'(`PPU_SCREEN_HEIGHT - 1);
  localparam logic [7:0]  COL_STEP  = 8'(`PPU_ROW_PIXELS);
  localparam logic [14:0] ADDR_STEP = 15'(`PPU_ROW_PIXELS);

  logic        pop_q;
  logic [7:0]  col;
  logic [7:0]  line;
  logic [14:0] addr;
  logic        line_end;
  logic        frame_end;
  logic        line_done_q;
  logic        frame_done_q;
  logic [7:0]  ly_q;

  // Pop while drawing, never two cycles back to back
  assign pop = dot_en && !fifo_empty && !pop_q;

  // Head row goes straight to the frame store in the pop cycle
  assign wr_en   = pop;
  assign wr_addr = addr;
  assign wr_row  = head_row;

  assign line_end  = (col == LAST_COL);
  assign frame_end = line_end && (line == LAST_LINE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pop_q        <= 1'b0;
      col          <= '0;
      line         <= '0;
      addr         <= '0;
      line_done_q  <= 1'b0;
      frame_done_q <= 1'b0;
      ly_q         <= '0;
    end else if (flush) begin
      // Restart at the top left corner
      pop_q        <= 1'b0;
      col          <= '0;
      line         <= '0;
      addr         <= '0;
      line_done_q  <= 1'b0;
      frame_done_q <= 1'b0;
      ly_q         <= '0;
    end else begin
      pop_q        <= pop;
      // Pulses one cycle after the last pop of a line
      line_done_q  <= pop && line_end;
      frame_done_q <= pop && frame_end;
      // Lags line by a cycle so ly matches the pulse
      ly_q         <= line;
      if (pop) begin
        if (line_end) begin
          col <= '0;
          if (frame_end) begin
            line <= '0;
            addr <= '0;
          end else begin
            line <= line + 8'd1;
            addr <= addr + ADDR_STEP;
          end
        end else begin
          col  <= col + COL_STEP;
          addr <= addr + ADDR_STEP;
        end
      end
    end
  end

  assign status.line_done  = line_done_q;
  assign status.frame_done = frame_done_q;
  assign status.ly         = ly_q;

endmodule

/* source/frame_store.sv */
`timescale 1ns/10ps

`include "ppu_params.svh"

module frame_store
  import ppu_types_pkg::*;
(
  input  logic        clk,
  input  logic        wr_en,
  input  logic [14:0] wr_addr,
  input  pixel_row_t  wr_row,
  input  logic [14:0] rd_addr,
  output gb_color_t   rd_data
);

  // 160 x 144 shades
  localparam int NUM_PIXELS = `PPU_SCREEN_WIDTH * `PPU_SCREEN_HEIGHT;

  gb_color_t mem [NUM_PIXELS];

  // Eight consecutive shades per write
  // Row index 0 lands at wr_addr, the leftmost pixel
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < `PPU_ROW_PIXELS; i++) begin
        mem[wr_addr + 15'(i)] <= wr_row[i];
      end
    end
  end

  // Registered read, data one cycle after rd_addr
  // A read of a pixel being written returns the old shade
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* source/ppu_pixel_top.sv */
`timescale 1ns/10ps

module ppu_pixel_top
  import ppu_types_pkg::*;
  import ppu_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        dot_en,
  input  logic        tile_valid,
  input  tile_row_t   tile_row,
  input  palette_t    bgp,
  output logic        tile_ready,
  input  logic [14:0] rd_addr,
  output gb_color_t   rd_data,
  output fb_status_t  status
);

  // Fetcher to FIFO
  logic       push;
  pixel_row_t push_row;
  logic       fifo_full;

  // FIFO to writer
  logic       fifo_empty;
  pixel_row_t head_row;
  logic       pop;

  // Writer to frame store
  logic        wr_en;
  logic [14:0] wr_addr;
  pixel_row_t  wr_row;

  pixel_row_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .tile_valid (tile_valid),
    .tile_row   (tile_row),
    .bgp        (bgp),
    .tile_ready (tile_ready),
    .fifo_full  (fifo_full),
    .push       (push),
    .push_row   (push_row)
  );

  // Default depth from the params header
  pixel_row_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .push     (push),
    .push_row (push_row),
    .pop      (pop),
    .head_row (head_row),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  framebuffer_writer u_writer (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .dot_en     (dot_en),
    .fifo_empty (fifo_empty),
    .head_row   (head_row),
    .pop        (pop),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_row     (wr_row),
    .status     (status)
  );

  frame_store u_store (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_row  (wr_row),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  // Half of the 8 ns period
  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

/* dv/tb_ppu_pixel.sv */
`timescale 1ns/10ps

`include "ppu_params.svh"

module tb_ppu_pixel
  import ppu_types_pkg::*;
  import ppu_ctrl_pkg::*;
();

  localparam int NUM_VECS      = 24;
  localparam int ROW_PIX       = `PPU_ROW_PIXELS;
  localparam int ROWS_PER_LINE = `PPU_SCREEN_WIDTH / `PPU_ROW_PIXELS;
  localparam int FRAME_ROWS    = ROWS_PER_LINE * `PPU_SCREEN_HEIGHT;
  localparam int LAST_LINE     = `PPU_SCREEN_HEIGHT - 1;
  localparam int READY_TIMEOUT = 1000;
  localparam int FRAME_TIMEOUT = 2000;

  logic        clk;
  logic        reset;
  logic        flush;
  logic        dot_en;
  logic        tile_valid;
  tile_row_t   tile_row;
  palette_t    bgp;
  logic        tile_ready;
  logic [14:0] rd_addr;
  gb_color_t   rd_data;
  fb_status_t  status;

  // Vector layout: palette, plane_hi, plane_lo, expected row
  logic [39:0] golden_mem [NUM_VECS];
  integer      seed = 32'h5b2e_3b81;
  logic        draw_enable;
  int          exp_ly;
  int          frames_done;
  int          low_run;
  int          stall_events;
  fb_status_t  exp_status;

  tb_clock_gen u_clk_gen (.clk(clk));

  ppu_pixel_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .dot_en     (dot_en),
    .tile_valid (tile_valid),
    .tile_row   (tile_row),
    .bgp        (bgp),
    .tile_ready (tile_ready),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .status     (status)
  );

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_color(input string name, input gb_color_t got, input gb_color_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_row(input string name, input pixel_row_t got, input pixel_row_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input fb_status_t got, input fb_status_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Row n of a frame takes vector (n + rot) mod 24
  function automatic int vec_of(input int n, input int rot);
    return (n + rot) % NUM_VECS;
  endfunction

  function automatic pixel_row_t golden_row(input int n, input int rot);
    return golden_mem[vec_of(n, rot)][15:0];
  endfunction

  // Random drawing stalls, dot_en low about a quarter of the time
  always begin
    @(posedge clk);
    #1;
    if (draw_enable) dot_en = (($random(seed) & 3) != 0);
    else dot_en = 1'b0;
  end

  // Status every cycle, pulses carry the finished line
  always @(negedge clk) begin
    if (!reset) begin
      exp_status.line_done  = status.line_done;
      exp_status.frame_done = status.line_done && (exp_ly == LAST_LINE);
      exp_status.ly         = 8'(exp_ly);
      check_status("status", status, exp_status);
      if (status.line_done) begin
        if (exp_ly == LAST_LINE) begin
          exp_ly = 0;
          frames_done++;
        end else begin
          exp_ly++;
        end
      end
      // Low for more than the push cycle means FIFO back-pressure
      if (tile_valid && !tile_ready) low_run++;
      else low_run = 0;
      if (low_run == 2) stall_events++;
    end
  end

  // Entered and left 1 ns after a rising edge
  task automatic send_rows(input int count, input int rot);
    int waited;
    for (int n = 0; n < count; n++) begin
      bgp        = golden_mem[vec_of(n, rot)][39:32];
      tile_row   = golden_mem[vec_of(n, rot)][31:16];
      tile_valid = 1'b1;
      waited     = 0;
      @(negedge clk);
      while (!tile_ready) begin
        if (waited == READY_TIMEOUT) report_timeout("tile_ready");
        waited++;
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      tile_valid = 1'b0;
    end
  endtask

  task automatic wait_frame(input int target);
    int waited;
    waited = 0;
    // Last row of the frame was just taken, its write is still ahead
    if (frames_done != target - 1) begin
      $display("frame_done came before all rows of the frame were sent");
      abort_run();
    end
    while (frames_done < target) begin
      if (waited == FRAME_TIMEOUT) report_timeout("frame_done");
      waited++;
      @(posedge clk);
    end
    #1;
  endtask

  // Registered read port, data one cycle after the address
  task automatic read_pixel(input int addr, output gb_color_t value);
    rd_addr = 15'(addr);
    @(posedge clk);
    @(negedge clk);
    value = rd_data;
    @(posedge clk);
    #1;
  endtask

  // Row n sits at line n/20, column 8*(n%20)
  task automatic check_frame(input int rot);
    pixel_row_t got;
    gb_color_t  pix;
    int         base;
    for (int n = 0; n < FRAME_ROWS; n++) begin
      base = (n / ROWS_PER_LINE) * `PPU_SCREEN_WIDTH + (n % ROWS_PER_LINE) * ROW_PIX;
      for (int i = 0; i < ROW_PIX; i++) begin
        read_pixel(base + i, pix);
        got[i] = pix;
      end
      check_row($sformatf("rd_data row %0d", n), got, golden_row(n, rot));
    end
  endtask

  // Top left and bottom right pixels, addresses on back-to-back cycles
  task automatic check_corners(input int rot);
    pixel_row_t first_row;
    pixel_row_t last_row;
    first_row = golden_row(0, rot);
    last_row  = golden_row(FRAME_ROWS - 1, rot);
    rd_addr = '0;
    @(posedge clk);
    #1;
    rd_addr = 15'(FRAME_ROWS * ROW_PIX - 1);
    @(negedge clk);
    check_color("rd_data pixel 0", rd_data, first_row[0]);
    @(posedge clk);
    @(negedge clk);
    check_color("rd_data last pixel", rd_data, last_row[ROW_PIX-1]);
    @(posedge clk);
    #1;
  endtask

  initial begin
    reset        = 1'b1;
    flush        = 1'b0;
    dot_en       = 1'b0;
    tile_valid   = 1'b0;
    tile_row     = '0;
    bgp          = '0;
    rd_addr      = '0;
    draw_enable  = 1'b0;
    exp_ly       = 0;
    frames_done  = 0;
    low_run      = 0;
    stall_events = 0;
    $readmemh("dv/ppu_pixel_golden.hex", golden_mem);
    for (int v = 0; v < NUM_VECS; v++) begin
      if ($isunknown(golden_mem[v])) begin
        $display("Golden vector %0d is missing or unreadable", v);
        abort_run();
      end
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    if (tile_ready !== 1'b1) begin
      $display("tile_ready is not high after reset");
      abort_run();
    end

    // First frame with random stalls
    draw_enable = 1'b1;
    send_rows(FRAME_ROWS, 0);
    wait_frame(1);
    check_frame(0);
    check_corners(0);

    // Rotated frame over the first one
    send_rows(FRAME_ROWS, 1);
    wait_frame(2);
    check_frame(1);
    check_corners(1);

    // Partial frame, stop drawing, then flush
    send_rows(1000, 2);
    draw_enable = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush  = 1'b0;
    exp_ly = 0;
    draw_enable = 1'b1;
    send_rows(FRAME_ROWS, 3);
    wait_frame(3);
    check_frame(3);
    check_corners(3);

    if (stall_events == 0) begin
      $display("tile_ready never dropped for a full FIFO");
      abort_run();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* dv/ppu_pixel_golden.hex */
// palette[39:32] plane_hi[31:24] plane_lo[23:16] expected_row[15:0]
// expected_row holds pixel 0 in bits 15:14 and pixel 7 in bits 1:0
e400000000
e400ff5555
e4ff00aaaa
e4ffffffff
1b0000ffff
1b0ff0aa55
e40ff055aa
e4aa559999
e455aa6666
e43c7e1ff4
00a53c0000
ff1234ffff
d281424aa1
93f0cca50f
e401804002
6c000f00ff
6cf0ff55ff
e4c399e14b
39660f7d82
e480018001
1bffff0000
1be7185695
c65a3c87d2
e4330f0a5f

/* flist.f */
+incdir+source
source/ppu_types_pkg.sv
source/ppu_ctrl_pkg.sv
source/pixel_row_fetcher.sv
source/pixel_row_fifo.sv
source/framebuffer_writer.sv
source/frame_store.sv
source/ppu_pixel_top.sv
dv/tb_clock_gen.sv
dv/tb_ppu_pixel.sv

/* Bender.yml */
package:
  name: ppu_pixel

sources:
  - include_dirs:
      - source
    files:
      - source/ppu_types_pkg.sv
      - source/ppu_ctrl_pkg.sv
      - source/pixel_row_fetcher.sv
      - source/pixel_row_fifo.sv
      - source/framebuffer_writer.sv
      - source/frame_store.sv
      - source/ppu_pixel_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_ppu_pixel.sv
